//--- verilog/uart_bridge_defs.svh
// uart bridge defaults for baud divider, command buffer depth and opcode bytes
`ifndef UART_BRIDGE_DEFS_SVH
`define UART_BRIDGE_DEFS_SVH

// clocks per serial bit
`define UART_BAUD_DIV 16

// commands buffered between decoder and gateway
`define CMD_FIFO_DEPTH 4

// opcode byte values, ascii 'W' and 'R'
`define OPC_WRITE 8'h57
`define OPC_READ 8'h52

`endif

//--- verilog/uart_bridge_pkg.sv
// uart bridge types shared by decoder, command buffer, gateway and fabric ports
`default_nettype none

package uart_bridge_pkg;

  // one host command after frame decode
  typedef struct packed {
    logic        write;      // 1 write, 0 read
    logic [31:0] addr;
    logic [31:0] data;       // don't care for reads
  } bridge_cmd_t;

  // request toward the tile fabric
  typedef struct packed {
    logic        write;      // 1 for write, 0 for read
    logic [31:0] addr;
    logic [31:0] data;
    logic [1:0]  thread_id;
  } fab_req_t;

  // read response from the fabric, one cycle pulse
  typedef struct packed {
    logic [31:0] data;
    logic [1:0]  thread_id;
  } fab_rsp_t;

endpackage

`default_nettype wire

//--- verilog/uart_rx.sv
// uart receiver, samples mid-bit and strobes out one byte per good frame
`default_nettype none
`timescale 1ns/1ps

`include "uart_bridge_defs.svh"

module uart_rx (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rx_line,
  output logic       rx_valid,
  output logic [7:0] rx_byte
);

  localparam int DIV = `UART_BAUD_DIV;
  localparam int CW  = $clog2(DIV);

  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

  rx_state_t     state;
  logic [1:0]    sync_q;     // two flop synchronizer
  logic          line_s;
  logic [CW-1:0] cnt;
  logic [2:0]    bit_idx;
  logic [7:0]    shreg;

  assign line_s  = sync_q[1];
  assign rx_byte = shreg;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_q <= 2'b11;       // idle line is high
    end else begin
      sync_q <= {sync_q[0], rx_line};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= RX_IDLE;
      cnt      <= '0;
      bit_idx  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      case (state)
        RX_IDLE: begin
          cnt <= '0;
          if (!line_s) state <= RX_START;  // falling edge of start bit
        end
        RX_START: begin
          if (cnt == CW'(DIV / 2 - 1)) begin
            cnt     <= '0;
            bit_idx <= '0;
            state   <= line_s ? RX_IDLE : RX_DATA;  // high here means a glitch
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        RX_DATA: begin
          if (cnt == CW'(DIV - 1)) begin
            cnt     <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) state <= RX_STOP;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        RX_STOP: begin
          if (cnt == CW'(DIV - 1)) begin
            rx_valid <= line_s;    // low stop bit drops the byte
            state    <= RX_IDLE;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // lsb arrives first
  always_ff @(posedge clk) begin
    if (state == RX_DATA && cnt == CW'(DIV - 1)) shreg <= {line_s, shreg[7:1]};
  end

endmodule

`default_nettype wire

//--- verilog/uart_tx.sv
// uart transmitter, shifts one byte out framed by start and stop bits
`default_nettype none
`timescale 1ns/1ps

`include "uart_bridge_defs.svh"

module uart_tx (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       tx_start,
  input  logic [7:0] tx_byte,
  output logic       tx_busy,
  output logic       tx_line
);

  localparam int DIV = `UART_BAUD_DIV;
  localparam int CW  = $clog2(DIV);

  logic [9:0]    shreg;      // {stop, data, start}
  logic [3:0]    bits_left;
  logic [CW-1:0] cnt;

  assign tx_line = shreg[0];
  assign tx_busy = (bits_left != 4'd0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      shreg     <= '1;         // line idles high
      bits_left <= '0;
      cnt       <= '0;
    end else if (tx_start) begin
      shreg     <= {1'b1, tx_byte, 1'b0};
      bits_left <= 4'd10;
      cnt       <= '0;
    end else if (tx_busy) begin
      if (cnt == CW'(DIV - 1)) begin
        cnt       <= '0;
        shreg     <= {1'b1, shreg[9:1]};  // refill with idle level
        bits_left <= bits_left - 1'b1;
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  // the gateway must wait for the stop bit before the next byte
  a_no_start_busy: assert property (
    @(posedge clk) disable iff (!rst_n) tx_start |-> !tx_busy
  ) else $error("uart_tx: new byte started while previous one is still shifting");

endmodule

`default_nettype wire

//--- verilog/cmd_decoder.sv
// command decoder, builds commands from received bytes and flags lost frames
`default_nettype none
`timescale 1ns/1ps

`include "uart_bridge_defs.svh"

module cmd_decoder
  import uart_bridge_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        rx_valid,
  input  logic [7:0]  rx_byte,
  input  logic        full,
  output logic        push,
  output bridge_cmd_t cmd,
  output logic        lost
);

  typedef enum logic [1:0] {DEC_OPC, DEC_ADDR, DEC_DATA} dec_state_t;

  dec_state_t  state;
  logic [1:0]  byte_cnt;     // wraps after four bytes
  logic        done;         // frame complete, one cycle
  bridge_cmd_t cmd_q;

  assign cmd  = cmd_q;
  assign push = done & ~full;  // no room, frame is dropped

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= DEC_OPC;
      byte_cnt <= '0;
      done     <= 1'b0;
      lost     <= 1'b0;
    end else begin
      done <= 1'b0;
      if (done && full) lost <= 1'b1;
      if (rx_valid) begin
        case (state)
          DEC_OPC: begin
            byte_cnt <= '0;
            if (rx_byte == `OPC_WRITE || rx_byte == `OPC_READ) begin
              state <= DEC_ADDR;
            end else begin
              lost <= 1'b1;      // unknown opcode, stay in opcode phase
            end
          end
          DEC_ADDR: begin
            byte_cnt <= byte_cnt + 1'b1;
            if (byte_cnt == 2'd3) begin
              if (cmd_q.write) begin
                state <= DEC_DATA;
              end else begin
                state <= DEC_OPC;
                done  <= 1'b1;
              end
            end
          end
          DEC_DATA: begin
            byte_cnt <= byte_cnt + 1'b1;
            if (byte_cnt == 2'd3) begin
              state <= DEC_OPC;
              done  <= 1'b1;
            end
          end
          default: state <= DEC_OPC;
        endcase
      end
    end
  end

  // msb first for both address and data
  always_ff @(posedge clk) begin
    if (rx_valid) begin
      case (state)
        DEC_OPC:  cmd_q.write <= (rx_byte == `OPC_WRITE);
        DEC_ADDR: cmd_q.addr  <= {cmd_q.addr[23:0], rx_byte};
        DEC_DATA: cmd_q.data  <= {cmd_q.data[23:0], rx_byte};
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- verilog/cmd_fifo.sv
// command FIFO, circular buffer between frame decoder and fabric gateway
`default_nettype none
`timescale 1ns/1ps

`include "uart_bridge_defs.svh"

module cmd_fifo
  import uart_bridge_pkg::*;
#(
  parameter int DEPTH = `CMD_FIFO_DEPTH
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        push,
  input  bridge_cmd_t push_cmd,
  output logic        full,
  input  logic        pop,
  output bridge_cmd_t head,
  output logic        not_empty
);

  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int NW = $clog2(DEPTH + 1);

  bridge_cmd_t   mem [DEPTH];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [NW-1:0] count;

  function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] ptr);
    return (ptr == PW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign head      = mem[rd_ptr];
  assign not_empty = (count != '0);
  assign full      = (count == NW'(DEPTH));

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= push_cmd;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= next_ptr(wr_ptr);
      if (pop)  rd_ptr <= next_ptr(rd_ptr);
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;               // both or neither, level unchanged
      endcase
    end
  end

  a_no_overflow: assert property (
    @(posedge clk) disable iff (!rst_n) push |-> !full
  ) else $error("cmd_fifo: push while full");

  a_no_underflow: assert property (
    @(posedge clk) disable iff (!rst_n) pop |-> not_empty
  ) else $error("cmd_fifo: pop while empty");

endmodule

`default_nettype wire

//--- verilog/fabric_gateway.sv
// fabric gateway, turns buffered commands into fabric requests and returns read data
`default_nettype none
`timescale 1ns/1ps

module fabric_gateway
  import uart_bridge_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  bridge_cmd_t head,
  input  logic        not_empty,
  output logic        pop,
  output logic        fab_req_valid,
  output fab_req_t    fab_req,
  input  logic        fab_stall,
  input  logic        fab_rsp_valid,
  input  fab_rsp_t    fab_rsp,
  output logic        tx_start,
  output logic [7:0]  tx_byte,
  input  logic        tx_busy
);

  typedef enum logic [1:0] {GW_IDLE, GW_REQ, GW_WAIT, GW_SEND} gw_state_t;

  gw_state_t   state;
  fab_req_t    req_q;
  logic [31:0] rd_data;      // shifts left as bytes go out
  logic [2:0]  sent;         // bytes handed to the transmitter
  logic        tx_slot;      // transmitter free and no start in flight

  assign pop           = (state == GW_IDLE) && not_empty;
  assign fab_req_valid = (state == GW_REQ);
  assign fab_req       = req_q;
  assign tx_slot       = (state == GW_SEND) && !tx_busy && !tx_start;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= GW_IDLE;
      sent     <= '0;
      tx_start <= 1'b0;
    end else begin
      tx_start <= 1'b0;
      case (state)
        GW_IDLE: begin
          if (not_empty) state <= GW_REQ;  // pop happens this cycle
        end
        GW_REQ: begin
          if (!fab_stall) state <= req_q.write ? GW_IDLE : GW_WAIT;
        end
        GW_WAIT: begin
          if (fab_rsp_valid) begin
            state <= GW_SEND;
            sent  <= '0;
          end
        end
        GW_SEND: begin
          if (tx_slot) begin
            if (sent == 3'd4) begin
              state <= GW_IDLE;    // last stop bit is out
            end else begin
              tx_start <= 1'b1;
              sent     <= sent + 1'b1;
            end
          end
        end
        default: state <= GW_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      req_q <= '{write: head.write, addr: head.addr, data: head.data, thread_id: 2'b00};
    end
  end

  always_ff @(posedge clk) begin
    if (state == GW_WAIT && fab_rsp_valid) begin
      rd_data <= fab_rsp.data;
    end else if (tx_slot && sent != 3'd4) begin
      tx_byte <= rd_data[31:24];   // msb first
      rd_data <= {rd_data[23:0], 8'h00};
    end
  end

  // fabric may only sample a request that holds steady under stall
  a_req_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    fab_req_valid && fab_stall |=> fab_req_valid && $stable(fab_req)
  ) else $error("fabric_gateway: request changed while stalled");

  // single outstanding read, so a response only fits the wait state
  a_rsp_expected: assert property (
    @(posedge clk) disable iff (!rst_n)
    fab_rsp_valid |-> state == GW_WAIT && fab_rsp.thread_id == req_q.thread_id
  ) else $error("fabric_gateway: unexpected fabric response");

endmodule

`default_nettype wire

//--- verilog/uart_io.sv
// uart debug bridge top, serial pins to tile fabric request and response ports
`default_nettype none
`timescale 1ns/1ps

`include "uart_bridge_defs.svh"

module uart_io
  import uart_bridge_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     rx_line,
  output logic     tx_line,
  output logic     fab_req_valid,
  output fab_req_t fab_req,
  input  logic     fab_stall,
  input  logic     fab_rsp_valid,
  input  fab_rsp_t fab_rsp,
  output logic     interrupt
);

  logic        rx_valid;
  logic [7:0]  rx_byte;
  logic        push;
  bridge_cmd_t dec_cmd;
  logic        full;
  bridge_cmd_t head;
  logic        not_empty;
  logic        pop;
  logic        tx_start;
  logic [7:0]  tx_byte;
  logic        tx_busy;

  uart_rx i_uart_rx (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx_line  (rx_line),
    .rx_valid (rx_valid),
    .rx_byte  (rx_byte)
  );

  cmd_decoder i_cmd_decoder (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx_valid (rx_valid),
    .rx_byte  (rx_byte),
    .full     (full),
    .push     (push),
    .cmd      (dec_cmd),
    .lost     (interrupt)    // sticky until reset
  );

  cmd_fifo #(
    .DEPTH (`CMD_FIFO_DEPTH)
  ) i_cmd_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (push),
    .push_cmd  (dec_cmd),
    .full      (full),
    .pop       (pop),
    .head      (head),
    .not_empty (not_empty)
  );

  fabric_gateway i_fabric_gateway (
    .clk           (clk),
    .rst_n         (rst_n),
    .head          (head),
    .not_empty     (not_empty),
    .pop           (pop),
    .fab_req_valid (fab_req_valid),
    .fab_req       (fab_req),
    .fab_stall     (fab_stall),
    .fab_rsp_valid (fab_rsp_valid),
    .fab_rsp       (fab_rsp),
    .tx_start      (tx_start),
    .tx_byte       (tx_byte),
    .tx_busy       (tx_busy)
  );

  uart_tx i_uart_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx_busy  (tx_busy),
    .tx_line  (tx_line)
  );

endmodule

`default_nettype wire

//--- tests/tb_uart_io.sv
// testbench for the uart debug bridge with a host serial model and a fabric memory model
`default_nettype none
`timescale 1ns/1ps

`include "uart_bridge_defs.svh"

module tb_uart_io
  import uart_bridge_pkg::*;
();

  localparam int DIV      = `UART_BAUD_DIV;
  localparam int DEPTH    = `CMD_FIFO_DEPTH;
  localparam int N_FRAMES = 40;    // upper bound on frames sent over the whole run
  localparam int TIMEOUT  = N_FRAMES * 9 * 10 * DIV + 20000;
  localparam logic [31:0] ADDR_BASE = 32'h4000_0a60;  // eight words from here

  logic     clk = 1'b0;
  logic     rst_n;
  logic     rx_line;
  logic     tx_line;
  logic     fab_req_valid;
  fab_req_t fab_req;
  logic     fab_stall;
  logic     fab_rsp_valid;
  fab_rsp_t fab_rsp;
  logic     interrupt;

  bridge_cmd_t exp_q [$];          // commands the fabric should see in order
  logic [31:0] exp_rd [$];         // words the host should get back
  logic [31:0] fab_mem [8];
  logic [31:0] ref_mem [8];
  logic        written [8];
  logic        stall_hold = 1'b0;
  logic        hold_prev = 1'b0;
  fab_req_t    prev_req;
  int          rsp_wait = 0;
  logic [2:0]  rsp_idx;
  int          cycles = 0;
  int          nbytes = 0;
  logic [7:0]  got_byte;
  logic [31:0] got_word;
  logic [31:0] exp_word;

  uart_io i_dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .rx_line       (rx_line),
    .tx_line       (tx_line),
    .fab_req_valid (fab_req_valid),
    .fab_req       (fab_req),
    .fab_stall     (fab_stall),
    .fab_rsp_valid (fab_rsp_valid),
    .fab_rsp       (fab_rsp),
    .interrupt     (interrupt)
  );

  always #2 clk = ~clk;

  function automatic logic [31:0] init_word(input logic [31:0] addr);
    return (addr * 32'h9e37_79b1) ^ 32'h5a3c_96e1;
  endfunction

  function automatic logic [31:0] idx_addr(input int idx);
    return ADDR_BASE | (32'(idx) << 2);
  endfunction

  // last written word or else the power-up content
  function automatic logic [31:0] expected_read(input logic [31:0] addr);
    if (written[addr[4:2]]) return ref_mem[addr[4:2]];
    return init_word(addr);
  endfunction

  task automatic fail_run(input string why);
    $display("error: %s", why);
    $display("*** FAILED ***");
    $fatal(1, "run stopped on first error");
  endtask

  task automatic check_val(input string name, input logic [67:0] got, input logic [67:0] exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
      fail_run("value mismatch");
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #1 rst_n = 1'b0;
    repeat (16) @(posedge clk);
    #1 rst_n = 1'b1;
  endtask

  // one 8N1 character sent lsb first
  task automatic send_byte(input logic [7:0] b);
    logic [9:0] bits;
    bits = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      #1 rx_line = bits[i];
      repeat (DIV - 1) @(posedge clk);
    end
  endtask

  task automatic send_frame(input logic [7:0] opc, input logic [31:0] addr,
                            input logic [31:0] data);
    send_byte(opc);
    for (int i = 3; i >= 0; i--) send_byte(addr[8*i +: 8]);
    if (opc == `OPC_WRITE) begin
      for (int i = 3; i >= 0; i--) send_byte(data[8*i +: 8]);
    end
  endtask

  task automatic queue_write(input int idx, input logic [31:0] data);
    bridge_cmd_t cmd;
    cmd.write = 1'b1;
    cmd.addr  = idx_addr(idx);
    cmd.data  = data;
    exp_q.push_back(cmd);
    ref_mem[idx] = data;
    written[idx] = 1'b1;
    send_frame(`OPC_WRITE, cmd.addr, data);
  endtask

  task automatic queue_read(input int idx);
    bridge_cmd_t cmd;
    cmd.write = 1'b0;
    cmd.addr  = idx_addr(idx);
    cmd.data  = '0;
    exp_q.push_back(cmd);
    exp_rd.push_back(expected_read(cmd.addr));
    send_frame(`OPC_READ, cmd.addr, 32'h0);
  endtask

  task automatic wait_idle();
    while (exp_q.size() != 0 || exp_rd.size() != 0) @(posedge clk);
  endtask

  task automatic wait_irq();
    int n;
    n = 0;
    while (interrupt !== 1'b1 && n < 2 * DIV) begin
      @(posedge clk);
      n++;
    end
    if (interrupt !== 1'b1) fail_run("interrupt not raised after a lost frame");
  endtask

  // called once the start bit has been seen low
  task automatic recv_byte(output logic [7:0] b);
    repeat (DIV / 2) @(negedge clk);
    if (tx_line !== 1'b0) fail_run("start bit on tx_line ended early");
    for (int i = 0; i < 8; i++) begin
      repeat (DIV) @(negedge clk);
      b[i] = tx_line;
    end
    repeat (DIV) @(negedge clk);
    if (tx_line !== 1'b1) fail_run("stop bit on tx_line is low");
  endtask

  task automatic check_request(input fab_req_t req);
    bridge_cmd_t exp_cmd;
    if (exp_q.size() == 0) begin
      fail_run("fabric request accepted with no command pending");
    end else begin
      exp_cmd = exp_q.pop_front();
      check_val("fab_req.write", req.write, exp_cmd.write);
      check_val("fab_req.addr", req.addr, exp_cmd.addr);
      check_val("fab_req.thread_id", req.thread_id, 2'b00);
      if (exp_cmd.write) begin
        check_val("fab_req.data", req.data, exp_cmd.data);
        fab_mem[req.addr[4:2]] = req.data;
      end else begin
        rsp_idx  = req.addr[4:2];
        rsp_wait = 1 + $urandom % 8;   // answer after 1 to 8 cycles
      end
    end
  endtask

  // fabric model samples on the edge and drives just after it
  always @(posedge clk) begin
    if (rst_n && hold_prev) begin
      check_val("fab_req_valid", fab_req_valid, 1'b1);
      check_val("fab_req", fab_req, prev_req);     // held under stall
    end
    hold_prev = rst_n && fab_req_valid && fab_stall;
    prev_req  = fab_req;
    if (rst_n && fab_req_valid && !fab_stall) check_request(fab_req);
    #1;
    fab_rsp_valid = 1'b0;
    if (rsp_wait > 0) begin
      rsp_wait = rsp_wait - 1;
      if (rsp_wait == 0) begin
        fab_rsp_valid     = 1'b1;
        fab_rsp.data      = fab_mem[rsp_idx];
        fab_rsp.thread_id = 2'b00;
      end
    end
    fab_stall = stall_hold || ($urandom % 4 == 0);
  end

  // host receive side where four bytes make one read word
  always begin
    @(negedge clk);
    if (rst_n && tx_line === 1'b0) begin
      recv_byte(got_byte);
      got_word = {got_word[23:0], got_byte};
      nbytes   = nbytes + 1;
      if (nbytes == 4) begin
        nbytes = 0;
        if (exp_rd.size() == 0) begin
          fail_run("read data on tx_line with no read pending");
        end else begin
          exp_word = exp_rd.pop_front();
          check_val("tx_line read word", got_word, exp_word);
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > TIMEOUT) begin
      fail_run($sformatf("timeout, run did not end within %0d cycles", TIMEOUT));
    end
  end

  initial begin
    void'($urandom(32'h0973edee));
    rst_n         = 1'b0;
    rx_line       = 1'b1;
    fab_stall     = 1'b0;
    fab_rsp_valid = 1'b0;
    fab_rsp       = '0;
    for (int i = 0; i < 8; i++) begin
      fab_mem[i] = init_word(idx_addr(i));
      ref_mem[i] = '0;
      written[i] = 1'b0;
    end
    apply_reset();
    check_val("tx_line", tx_line, 1'b1);
    check_val("fab_req_valid", fab_req_valid, 1'b0);
    check_val("interrupt", interrupt, 1'b0);

    repeat (12) queue_write($urandom % 8, $urandom);
    wait_idle();
    repeat (8) queue_read($urandom % 8);
    wait_idle();

    // long stalls with a full buffer's worth pending
    repeat (2) begin
      @(posedge clk);
      stall_hold = 1'b1;
      for (int i = 0; i < DEPTH; i++) begin
        if (i % 2 == 0) queue_write($urandom % 8, $urandom);
        else queue_read($urandom % 8);
      end
      @(posedge clk);
      stall_hold = 1'b0;
      wait_idle();
    end
    check_val("interrupt", interrupt, 1'b0);

    send_byte(8'h3f);              // not an opcode
    wait_irq();
    queue_write(3, 32'hc0de_0003);
    queue_read(3);
    wait_idle();
    check_val("interrupt", interrupt, 1'b1);

    // overflow leaves one command in the gateway and DEPTH in the FIFO
    stall_hold = 1'b1;
    apply_reset();
    check_val("interrupt", interrupt, 1'b0);
    for (int i = 0; i < DEPTH + 1; i++) queue_write(i % 7, $urandom);
    send_frame(`OPC_WRITE, idx_addr(7), 32'hdead_0007);  // dropped
    wait_irq();
    check_val("fab_req_valid", fab_req_valid, 1'b1);
    @(posedge clk);
    stall_hold = 1'b0;
    wait_idle();
    queue_read(7);                 // dropped write left no trace
    wait_idle();

    if (exp_q.size() != 0 || exp_rd.size() != 0 || nbytes != 0) begin
      fail_run("commands left over at end of run");
    end else begin
      $display("*** PASSED ***");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- compile.f
+incdir+verilog
verilog/uart_bridge_pkg.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/cmd_decoder.sv
verilog/cmd_fifo.sv
verilog/fabric_gateway.sv
verilog/uart_io.sv
tests/tb_uart_io.sv
